/* source/dbg_trig_pkg.sv */
// Debug trigger shared definitions
package dbg_trig_pkg;

  //////////////////////////////////////////////////////////////////////
  // Basic types
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;      // Data, address and CSR value
  typedef logic [11:0] csr_addr_t;  // CSR address
  typedef logic [1:0]  trig_idx_t;  // Trigger index, four triggers max

  // Trigger and debug CSR map
  localparam csr_addr_t CSR_TSELECT  = 12'h7A0;
  localparam csr_addr_t CSR_TDATA1   = 12'h7A1;
  localparam csr_addr_t CSR_TDATA2   = 12'h7A2;
  localparam csr_addr_t CSR_TDATA3   = 12'h7A3; // Reads as zero
  localparam csr_addr_t CSR_TINFO    = 12'h7A4;
  localparam csr_addr_t CSR_TCONTROL = 12'h7A5; // Reads as zero
  localparam csr_addr_t CSR_DPC      = 12'h7B1;

  localparam logic [3:0] TTYPE_MCONTROL = 4'd2; // Address/data match trigger

  //////////////////////////////////////////////////////////////////////
  // tdata1 layout
  //////////////////////////////////////////////////////////////////////

  // Reset value of every trigger, execute match off
  localparam word_t TDATA1_RST_VAL = {
    TTYPE_MCONTROL, // Trigger type
    1'b1,           // Writable from debug mode only
    6'h00,          // No mask matching
    1'b0,           // Hit bit not implemented
    1'b0,           // Address match only
    1'b0,           // Fire before execution
    2'b00,          // Any access size
    4'h1,           // Action enters debug mode
    1'b0,           // No chaining
    4'h0,           // Exact compare
    1'b1,           // Active in machine mode
    1'b0,           // Reserved
    1'b0,           // No supervisor mode
    1'b0,           // No user mode
    1'b0,           // Execute, the only writable field
    1'b0,           // No store match
    1'b0            // No load match
  };

  // Fixed part of a written tdata1, bit 2 comes from write data
  localparam word_t TDATA1_WR_FIXED = TDATA1_RST_VAL;

  localparam word_t TINFO_VAL = 32'h4; // Only mcontrol supported

  // Debug run state
  typedef enum logic {
    DBG_RUN    = 1'b0,
    DBG_HALTED = 1'b1
  } dbg_state_e;

endpackage

/* source/dbg_csr_decode.sv */
// Trigger CSR access decoder
module dbg_csr_decode (
  input  logic                    clk,
  input  logic                    reset_i,

  // CSR request
  input  logic                    csr_req_valid_i,
  output logic                    csr_req_ready_o,
  input  dbg_trig_pkg::csr_addr_t csr_addr_i,
  input  logic                    csr_we_i,
  input  dbg_trig_pkg::word_t     csr_wdata_i,

  // CSR response
  output logic                    csr_rsp_valid_o,
  input  logic                    csr_rsp_ready_i,
  output dbg_trig_pkg::word_t     csr_rsp_rdata_o,
  output logic                    csr_rsp_err_o,

  // From halt controller
  input  logic                    debug_mode_i,
  input  dbg_trig_pkg::word_t     dpc_i,

  // Trigger bank access
  input  dbg_trig_pkg::word_t     tselect_rdata_i,
  input  dbg_trig_pkg::word_t     tdata1_rdata_i,
  input  dbg_trig_pkg::word_t     tdata2_rdata_i,
  output dbg_trig_pkg::word_t     trig_wdata_o,
  output logic                    tselect_we_o,
  output logic                    tdata1_we_o,
  output logic                    tdata2_we_o
);

  import dbg_trig_pkg::*;

  logic  req_accept;   // Request handshake this cycle
  logic  trig_wr;      // Accepted write while halted
  word_t rd_value;     // Value before the access
  logic  addr_err;     // Address not in CSR map

  logic  rsp_valid_q;
  word_t rsp_rdata_q;
  logic  rsp_err_q;

  //////////////////////////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////////////////////////

  // Free slot, or held response leaves this cycle
  assign csr_req_ready_o = !rsp_valid_q || csr_rsp_ready_i;
  assign req_accept      = csr_req_valid_i && csr_req_ready_o;

  //////////////////////////////////////////////////////////////////////
  // Address decode and read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_value = '0;
    addr_err = 1'b0;
    case (csr_addr_i)
      CSR_TSELECT:  rd_value = tselect_rdata_i;
      CSR_TDATA1:   rd_value = tdata1_rdata_i;  // Selected trigger
      CSR_TDATA2:   rd_value = tdata2_rdata_i;  // Selected trigger
      CSR_TDATA3:   rd_value = '0;
      CSR_TINFO:    rd_value = TINFO_VAL;
      CSR_TCONTROL: rd_value = '0;
      CSR_DPC:      rd_value = dpc_i;
      default:      addr_err = 1'b1;            // Unmapped address
    endcase
  end

  // Trigger CSRs only change in debug mode, other writes are dropped silently
  assign trig_wr = req_accept && csr_we_i && debug_mode_i;

  assign tselect_we_o = trig_wr && (csr_addr_i == CSR_TSELECT);
  assign tdata1_we_o  = trig_wr && (csr_addr_i == CSR_TDATA1);
  assign tdata2_we_o  = trig_wr && (csr_addr_i == CSR_TDATA2);
  assign trig_wdata_o = csr_wdata_i;  // Legalised in the bank

  //////////////////////////////////////////////////////////////////////
  // Response register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_accept) begin
      rsp_valid_q <= 1'b1;              // Refill, possibly same cycle as take
    end else if (csr_rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Payload only loads on acceptance
  always_ff @(posedge clk) begin
    if (req_accept) begin
      rsp_rdata_q <= rd_value;
      rsp_err_q   <= addr_err;
    end
  end

  assign csr_rsp_valid_o = rsp_valid_q;
  assign csr_rsp_rdata_o = rsp_rdata_q;
  assign csr_rsp_err_o   = rsp_err_q;

endmodule

/* source/dbg_trigger_bank.sv */
// Execute address trigger bank
module dbg_trigger_bank #(
  parameter int DBG_NUM_TRIGGERS = 2
) (
  input  logic                clk,
  input  logic                reset_i,

  // CSR writes from decoder
  input  dbg_trig_pkg::word_t trig_wdata_i,
  input  logic                tselect_we_i,
  input  logic                tdata1_we_i,
  input  logic                tdata2_we_i,

  // CSR read data
  output dbg_trig_pkg::word_t tselect_rdata_o,
  output dbg_trig_pkg::word_t tdata1_rdata_o,
  output dbg_trig_pkg::word_t tdata2_rdata_o,

  // Fetch side
  input  dbg_trig_pkg::word_t fetch_pc_i,
  input  logic                fetch_ptr_i,
  output logic                trigger_match_o
);

  import dbg_trig_pkg::*;

  trig_idx_t tselect_q;                          // Selected trigger
  word_t     tdata1_q [DBG_NUM_TRIGGERS];        // Per trigger control
  word_t     tdata2_q [DBG_NUM_TRIGGERS];        // Per trigger match address

  logic      tselect_legal;                      // Write value in range
  word_t     tdata1_n;                           // Legalised tdata1
  logic      any_match;                          // Before pointer masking

  //////////////////////////////////////////////////////////////////////
  // Write legalisation
  //////////////////////////////////////////////////////////////////////

  // Out of range select values leave tselect alone
  assign tselect_legal = trig_wdata_i < word_t'(DBG_NUM_TRIGGERS);

  // Fixed mcontrol layout, execute taken from write data
  always_comb begin
    tdata1_n    = TDATA1_WR_FIXED;
    tdata1_n[2] = trig_wdata_i[2];
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      tselect_q <= '0;
    end else if (tselect_we_i && tselect_legal) begin
      tselect_q <= trig_idx_t'(trig_wdata_i[1:0]);
    end
  end

  // One flop set per implemented trigger, written through tselect
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < DBG_NUM_TRIGGERS; i++) begin
        tdata1_q[i] <= TDATA1_RST_VAL;
        tdata2_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < DBG_NUM_TRIGGERS; i++) begin
        if (tselect_q == trig_idx_t'(i)) begin
          if (tdata1_we_i) begin
            tdata1_q[i] <= tdata1_n;
          end
          if (tdata2_we_i) begin
            tdata2_q[i] <= trig_wdata_i;   // Full word, no legalisation
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read data
  //////////////////////////////////////////////////////////////////////

  assign tselect_rdata_o = {30'd0, tselect_q};

  // Selected trigger view
  always_comb begin
    tdata1_rdata_o = TDATA1_RST_VAL;
    tdata2_rdata_o = '0;
    for (int i = 0; i < DBG_NUM_TRIGGERS; i++) begin
      if (tselect_q == trig_idx_t'(i)) begin
        tdata1_rdata_o = tdata1_q[i];
        tdata2_rdata_o = tdata2_q[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Execute address match
  //////////////////////////////////////////////////////////////////////

  // Exact compare against each enabled trigger
  always_comb begin
    any_match = 1'b0;
    for (int i = 0; i < DBG_NUM_TRIGGERS; i++) begin
      if (tdata1_q[i][2] && (tdata2_q[i] == fetch_pc_i)) begin
        any_match = 1'b1;
      end
    end
  end

  // Pointer fetches never fire a trigger
  assign trigger_match_o = any_match && !fetch_ptr_i;

endmodule

/* source/dbg_halt_ctrl.sv */
// Debug halt controller
module dbg_halt_ctrl (
  input  logic                clk,
  input  logic                reset_i,

  // Fetch side
  input  logic                fetch_valid_i,
  output logic                fetch_ready_o,
  input  dbg_trig_pkg::word_t fetch_pc_i,
  input  logic                trigger_match_i,

  // Issue side
  output logic                issue_valid_o,
  input  logic                issue_ready_i,
  output dbg_trig_pkg::word_t issue_pc_o,

  // Debug control
  input  logic                halt_req_i,
  input  logic                dret_i,
  output logic                debug_mode_o,
  output dbg_trig_pkg::word_t dpc_o
);

  import dbg_trig_pkg::*;

  dbg_state_e state_q, state_n;
  logic       fetch_accept;     // Fetch handshake this cycle
  logic       enter_halt;       // Leaving run mode
  logic       issue_valid_q;
  word_t      issue_pc_q;
  word_t      dpc_q;

  //////////////////////////////////////////////////////////////////////
  // Fetch acceptance
  //////////////////////////////////////////////////////////////////////

  // Halt request wins over fetch, issue slot must be free or draining
  assign fetch_ready_o = (state_q == DBG_RUN) && !halt_req_i &&
                         (!issue_valid_q || issue_ready_i);
  assign fetch_accept  = fetch_valid_i && fetch_ready_o;

  assign enter_halt = (state_q == DBG_RUN) &&
                      (halt_req_i || (fetch_accept && trigger_match_i));

  //////////////////////////////////////////////////////////////////////
  // Run/halted FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_n = state_q;
    unique case (state_q)
      DBG_RUN:    if (enter_halt) state_n = DBG_HALTED;
      DBG_HALTED: if (dret_i)     state_n = DBG_RUN;     // dret ignored in run
      default:    state_n = DBG_RUN;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q       <= DBG_RUN;
      issue_valid_q <= 1'b0;
      dpc_q         <= '0;
    end else begin
      state_q <= state_n;
      if (enter_halt) begin
        dpc_q <= fetch_pc_i;              // Matched pc, or pc on offer at halt
      end
      if (fetch_accept && !trigger_match_i) begin
        issue_valid_q <= 1'b1;
      end else if (issue_ready_i) begin
        issue_valid_q <= 1'b0;
      end
    end
  end

  // Issue payload, matching fetches are consumed here
  always_ff @(posedge clk) begin
    if (fetch_accept && !trigger_match_i) begin
      issue_pc_q <= fetch_pc_i;
    end
  end

  assign issue_valid_o = issue_valid_q;
  assign issue_pc_o    = issue_pc_q;
  assign debug_mode_o  = (state_q == DBG_HALTED);
  assign dpc_o         = dpc_q;

endmodule

/* source/dbg_trig_top.sv */
// Debug trigger subsystem top
module dbg_trig_top #(
  parameter int DBG_NUM_TRIGGERS = 2
) (
  input  logic                    clk,
  input  logic                    reset_i,

  // CSR port
  input  logic                    csr_req_valid_i,
  output logic                    csr_req_ready_o,
  input  dbg_trig_pkg::csr_addr_t csr_addr_i,
  input  logic                    csr_we_i,
  input  dbg_trig_pkg::word_t     csr_wdata_i,
  output logic                    csr_rsp_valid_o,
  input  logic                    csr_rsp_ready_i,
  output dbg_trig_pkg::word_t     csr_rsp_rdata_o,
  output logic                    csr_rsp_err_o,

  // Fetch and issue
  input  logic                    fetch_valid_i,
  output logic                    fetch_ready_o,
  input  dbg_trig_pkg::word_t     fetch_pc_i,
  input  logic                    fetch_ptr_i,
  output logic                    issue_valid_o,
  input  logic                    issue_ready_i,
  output dbg_trig_pkg::word_t     issue_pc_o,

  // Debug control
  input  logic                    halt_req_i,
  input  logic                    dret_i,
  output logic                    debug_mode_o
);

  import dbg_trig_pkg::*;

  word_t trig_wdata;       // Decoder to bank
  logic  tselect_we;
  logic  tdata1_we;
  logic  tdata2_we;
  word_t tselect_rdata;    // Bank to decoder
  word_t tdata1_rdata;
  word_t tdata2_rdata;
  logic  trigger_match;    // Bank to halt controller
  word_t dpc;              // Halt controller to decoder

  //////////////////////////////////////////////////////////////////////
  // CSR decoder
  //////////////////////////////////////////////////////////////////////

  dbg_csr_decode u_csr_decode (
    .clk             (clk),
    .reset_i         (reset_i),
    .csr_req_valid_i (csr_req_valid_i),
    .csr_req_ready_o (csr_req_ready_o),
    .csr_addr_i      (csr_addr_i),
    .csr_we_i        (csr_we_i),
    .csr_wdata_i     (csr_wdata_i),
    .csr_rsp_valid_o (csr_rsp_valid_o),
    .csr_rsp_ready_i (csr_rsp_ready_i),
    .csr_rsp_rdata_o (csr_rsp_rdata_o),
    .csr_rsp_err_o   (csr_rsp_err_o),
    .debug_mode_i    (debug_mode_o),   // Gates trigger writes
    .dpc_i           (dpc),
    .tselect_rdata_i (tselect_rdata),
    .tdata1_rdata_i  (tdata1_rdata),
    .tdata2_rdata_i  (tdata2_rdata),
    .trig_wdata_o    (trig_wdata),
    .tselect_we_o    (tselect_we),
    .tdata1_we_o     (tdata1_we),
    .tdata2_we_o     (tdata2_we)
  );

  //////////////////////////////////////////////////////////////////////
  // Trigger bank
  //////////////////////////////////////////////////////////////////////

  dbg_trigger_bank #(
    .DBG_NUM_TRIGGERS (DBG_NUM_TRIGGERS)
  ) u_trigger_bank (
    .clk             (clk),
    .reset_i         (reset_i),
    .trig_wdata_i    (trig_wdata),
    .tselect_we_i    (tselect_we),
    .tdata1_we_i     (tdata1_we),
    .tdata2_we_i     (tdata2_we),
    .tselect_rdata_o (tselect_rdata),
    .tdata1_rdata_o  (tdata1_rdata),
    .tdata2_rdata_o  (tdata2_rdata),
    .fetch_pc_i      (fetch_pc_i),
    .fetch_ptr_i     (fetch_ptr_i),
    .trigger_match_o (trigger_match)
  );

  //////////////////////////////////////////////////////////////////////
  // Halt controller
  //////////////////////////////////////////////////////////////////////

  dbg_halt_ctrl u_halt_ctrl (
    .clk             (clk),
    .reset_i         (reset_i),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_pc_i      (fetch_pc_i),
    .trigger_match_i (trigger_match),
    .issue_valid_o   (issue_valid_o),
    .issue_ready_i   (issue_ready_i),
    .issue_pc_o      (issue_pc_o),
    .halt_req_i      (halt_req_i),
    .dret_i          (dret_i),
    .debug_mode_o    (debug_mode_o),
    .dpc_o           (dpc)
  );

endmodule

/* dv/dbg_trig_props.sv */
// Debug trigger interface properties
module dbg_trig_props (
  input logic                clk,
  input logic                reset_i,
  input logic                csr_rsp_valid_o,
  input logic                csr_rsp_ready_i,
  input dbg_trig_pkg::word_t csr_rsp_rdata_o,
  input logic                csr_rsp_err_o,
  input logic                issue_valid_o,
  input logic                issue_ready_i,
  input dbg_trig_pkg::word_t issue_pc_o,
  input logic                fetch_valid_i,
  input logic                fetch_ready_o,
  input logic                trigger_match,
  input logic                halt_req_i,
  input logic                debug_mode_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Held response keeps its payload until taken
  assert property (@(posedge clk) disable iff (reset_i)
    csr_rsp_valid_o && !csr_rsp_ready_i |=>
      csr_rsp_valid_o && $stable(csr_rsp_rdata_o) && $stable(csr_rsp_err_o))
    else $error("CSR response changed while stalled");

  assert property (@(posedge clk) disable iff (reset_i)
    issue_valid_o && !issue_ready_i |=> issue_valid_o && $stable(issue_pc_o))
    else $error("Issue changed while stalled");

  assert property (@(posedge clk) disable iff (reset_i)
    debug_mode_o |-> !fetch_ready_o)                      // No fetch while halted
    else $error("Fetch ready in debug mode");

  assert property (@(posedge clk)
    reset_i |=> !csr_rsp_valid_o && !issue_valid_o && !debug_mode_o)
    else $error("Output active after reset");

  // Halt needs a request or a matching fetch one cycle before
  assert property (@(posedge clk) disable iff (reset_i)
    $rose(debug_mode_o) |-> $past(halt_req_i || (fetch_valid_i && fetch_ready_o && trigger_match)))
    else $error("Debug mode entered without cause");

endmodule

bind dbg_trig_top dbg_trig_props u_props (.*);

/* dv/dbg_trig_tb.sv */
// Debug trigger subsystem testbench
module dbg_trig_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import dbg_trig_pkg::*;

  localparam int    NUM_TRIG     = 2;
  localparam word_t TDATA1_RESET = 32'h2800_1040;  // mcontrol, dmode, action 1, m
  localparam int    RAND_CYCLES  = 4000;
  localparam int    WAIT_LIMIT   = 200;             // Cycles per wait loop

  logic      clk = 1'b0;
  logic      reset_i;
  logic      csr_req_valid_i, csr_req_ready_o, csr_we_i;
  csr_addr_t csr_addr_i;
  word_t     csr_wdata_i, csr_rsp_rdata_o;
  logic      csr_rsp_valid_o, csr_rsp_ready_i, csr_rsp_err_o;
  logic      fetch_valid_i, fetch_ready_o, fetch_ptr_i;
  word_t     fetch_pc_i, issue_pc_o;
  logic      issue_valid_o, issue_ready_i;
  logic      halt_req_i, dret_i, debug_mode_o;

  integer    seed;
  word_t     model_tselect;                  // Reference model state
  word_t     model_tdata1 [NUM_TRIG];
  word_t     model_tdata2 [NUM_TRIG];
  logic      model_halted;
  word_t     model_dpc;
  word_t     exp_rdata_q [$];                // Expected responses in order
  logic      exp_err_q [$];
  word_t     exp_issue_q [$];                // Expected issued pcs
  logic      csr_fire, fetch_fire;           // Handshakes at the coming edge
  int        n_match, n_halt, n_trig_wr, n_gated_wr;

  // Directed reset reads ending on an unmapped address
  csr_addr_t reset_addr_list [8] = '{CSR_TSELECT, CSR_TDATA1, CSR_TDATA2, CSR_TDATA3,
                                      CSR_TINFO, CSR_TCONTROL, CSR_DPC, 12'h7C0};

  dbg_trig_top #(.DBG_NUM_TRIGGERS(NUM_TRIG)) u_dut (.*);

  always #20 clk = ~clk;  // 40 ns period

  task automatic report_fail(input string line);
    $display("%s", line);
    $display("Verification failed");
    $fatal(1, "Simulation stopped on first error");
  endtask

  function automatic logic one_in(input int n);
    return ($unsigned($random(seed)) % n) == 0;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////

  task automatic reset_model();
    model_tselect = '0;
    model_halted  = 1'b0;
    model_dpc     = '0;
    for (int i = 0; i < NUM_TRIG; i++) begin
      model_tdata1[i] = TDATA1_RESET;
      model_tdata2[i] = '0;
    end
    exp_rdata_q.delete();
    exp_err_q.delete();
    exp_issue_q.delete();
  endtask

  // Execute match on any enabled trigger unless the fetch is a pointer
  function automatic logic fetch_hits(input word_t pc, input logic ptr);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < NUM_TRIG; i++) begin
      if (model_tdata1[i][2] && (model_tdata2[i] == pc)) hit = 1'b1;
    end
    return hit && !ptr;
  endfunction

  // Read before write with trigger writes only while halted
  task automatic model_csr();
    word_t rd;
    logic  err;
    rd  = '0;
    err = 1'b0;
    case (csr_addr_i)
      CSR_TSELECT:  rd = model_tselect;
      CSR_TDATA1:   rd = model_tdata1[model_tselect];
      CSR_TDATA2:   rd = model_tdata2[model_tselect];
      CSR_TINFO:    rd = 32'h4;
      CSR_DPC:      rd = model_dpc;
      CSR_TDATA3, CSR_TCONTROL: rd = '0;
      default:      err = 1'b1;
    endcase
    exp_rdata_q.push_back(rd);
    exp_err_q.push_back(err);
    if (csr_we_i && csr_addr_i inside {CSR_TSELECT, CSR_TDATA1, CSR_TDATA2}) begin
      if (!model_halted) begin
        n_gated_wr++;                                   // Dropped outside debug
      end else begin
        n_trig_wr++;
        case (csr_addr_i)
          CSR_TSELECT: if (csr_wdata_i < NUM_TRIG) model_tselect = csr_wdata_i;
          CSR_TDATA1:  model_tdata1[model_tselect] = TDATA1_RESET | (csr_wdata_i & 32'h4);
          default:     model_tdata2[model_tselect] = csr_wdata_i;
        endcase
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Monitor sampling mid-cycle where everything is stable
  ////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : monitor
    logic  halted_n;
    word_t dpc_n;
    word_t exp_w;
    logic  exp_e;
    if (reset_i) begin
      reset_model();
      csr_fire   = 1'b0;
      fetch_fire = 1'b0;
    end else begin
      csr_fire   = csr_req_valid_i && csr_req_ready_o;
      fetch_fire = fetch_valid_i && fetch_ready_o;
      assert (debug_mode_o == model_halted) else report_fail($sformatf(
        "CHECK FAILED at %0t: debug_mode_o is %0b", $time, debug_mode_o));
      assert (csr_rsp_valid_o == (exp_rdata_q.size() != 0)) else report_fail($sformatf(
        "CHECK FAILED at %0t: csr_rsp_valid_o is %0b", $time, csr_rsp_valid_o));
      assert (issue_valid_o == (exp_issue_q.size() != 0)) else report_fail($sformatf(
        "CHECK FAILED at %0t: issue_valid_o is %0b", $time, issue_valid_o));
      assert (csr_req_ready_o == (exp_rdata_q.size() == 0 || csr_rsp_ready_i))
        else report_fail($sformatf("CHECK FAILED at %0t: wrong csr_req_ready_o", $time));
      assert (fetch_ready_o == (!model_halted && !halt_req_i &&
                                (exp_issue_q.size() == 0 || issue_ready_i)))
        else report_fail($sformatf("CHECK FAILED at %0t: wrong fetch_ready_o", $time));
      if (csr_rsp_valid_o && csr_rsp_ready_i) begin
        exp_w = exp_rdata_q.pop_front();
        exp_e = exp_err_q.pop_front();
        assert (csr_rsp_err_o == exp_e) else report_fail($sformatf(
          "CHECK FAILED at %0t: csr_rsp_err_o %0b, expected %0b", $time, csr_rsp_err_o, exp_e));
        assert (exp_e || csr_rsp_rdata_o == exp_w) else report_fail($sformatf(
          "CHECK FAILED at %0t: rdata %h, expected %h", $time, csr_rsp_rdata_o, exp_w));
      end
      if (issue_valid_o && issue_ready_i) begin
        exp_w = exp_issue_q.pop_front();
        assert (issue_pc_o == exp_w) else report_fail($sformatf(
          "CHECK FAILED at %0t: issue pc %h, expected %h", $time, issue_pc_o, exp_w));
      end
      halted_n = model_halted;
      dpc_n    = model_dpc;
      if (fetch_fire) begin
        if (fetch_hits(fetch_pc_i, fetch_ptr_i)) begin
          halted_n = 1'b1;                              // Consumed and its pc goes to dpc
          dpc_n    = fetch_pc_i;
          n_match++;
        end else begin
          exp_issue_q.push_back(fetch_pc_i);
        end
      end
      if (!model_halted && halt_req_i) begin
        halted_n = 1'b1;
        dpc_n    = fetch_pc_i;                          // pc on offer at halt
        n_halt++;
      end
      if (model_halted && dret_i) halted_n = 1'b0;
      if (csr_fire) model_csr();                        // Gated by current mode
      model_halted = halted_n;
      model_dpc    = dpc_n;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////

  function automatic csr_addr_t rand_addr();
    case ($unsigned($random(seed)) % 9)
      0:       return CSR_TSELECT;
      1:       return CSR_TDATA1;
      2:       return CSR_TDATA2;
      3:       return CSR_TDATA3;
      4:       return CSR_TINFO;
      5:       return CSR_TCONTROL;
      6:       return CSR_DPC;
      7:       return 12'h7B0;                          // Unmapped
      default: return 12'h300;
    endcase
  endfunction

  // One cycle of random traffic or of idle draining
  task automatic drive_cycle(input logic active);
    word_t base;
    @(posedge clk);
    #2;
    if (csr_fire) csr_req_valid_i = 1'b0;
    if (fetch_fire) fetch_valid_i = 1'b0;
    csr_rsp_ready_i = !one_in(4);
    issue_ready_i   = !one_in(4);
    if (active && !csr_req_valid_i && one_in(2)) begin
      csr_req_valid_i = 1'b1;
      csr_addr_i      = rand_addr();
      csr_we_i        = one_in(2);
      csr_wdata_i     = $random(seed);
      if (csr_addr_i == CSR_TSELECT) csr_wdata_i = $unsigned($random(seed)) % 4;
      if (csr_addr_i == CSR_TDATA2) csr_wdata_i = 32'h2000 + 4 * ($unsigned($random(seed)) % 8);
    end
    if (active && !fetch_valid_i && one_in(2)) begin
      base          = model_tdata2[$unsigned($random(seed)) % NUM_TRIG];
      fetch_valid_i = 1'b1;
      fetch_pc_i    = base + 4 * ($unsigned($random(seed)) % 3);   // Near a trigger
      fetch_ptr_i   = one_in(8);
    end
    halt_req_i = active && !debug_mode_o && one_in(40);
    dret_i     = active ? (debug_mode_o ? one_in(16) : one_in(64)) : debug_mode_o;
  endtask

  task automatic csr_access(input csr_addr_t addr, input logic we, input word_t wdata);
    int waited;
    waited = 0;
    @(posedge clk);
    #2;
    csr_req_valid_i = 1'b1;
    csr_addr_i      = addr;
    csr_we_i        = we;
    csr_wdata_i     = wdata;
    do begin
      @(posedge clk);
      #2;
      waited++;
    end while (!csr_fire && waited < WAIT_LIMIT);
    csr_req_valid_i = 1'b0;
    if (!csr_fire) report_fail($sformatf("CSR request to %h was never accepted", addr));
  endtask

  initial begin
    int   waited;
    logic drained;
    seed            = 32'hecb0;
    reset_i         = 1'b1;
    csr_req_valid_i = 1'b0;
    csr_addr_i      = '0;
    csr_we_i        = 1'b0;
    csr_wdata_i     = '0;
    csr_rsp_ready_i = 1'b1;
    fetch_valid_i   = 1'b0;
    fetch_pc_i      = '0;
    fetch_ptr_i     = 1'b0;
    issue_ready_i   = 1'b1;
    halt_req_i      = 1'b0;
    dret_i          = 1'b0;
    n_match         = 0;
    n_halt          = 0;
    n_trig_wr       = 0;
    n_gated_wr      = 0;
    repeat (10) @(posedge clk);
    #2;
    reset_i = 1'b0;

    // Reset values and a write outside debug mode
    foreach (reset_addr_list[i]) csr_access(reset_addr_list[i], 1'b0, '0);
    csr_access(CSR_TDATA2, 1'b1, 32'h1234_5678);
    csr_access(CSR_TDATA2, 1'b0, '0);

    repeat (RAND_CYCLES) drive_cycle(1'b1);

    waited  = 0;
    drained = 1'b0;
    while (!drained && waited < WAIT_LIMIT) begin
      drive_cycle(1'b0);
      waited++;
      drained = !(csr_req_valid_i || fetch_valid_i || debug_mode_o ||
                  exp_rdata_q.size() != 0 || exp_issue_q.size() != 0);
    end

    if (!drained) begin
      report_fail("Outstanding responses or issues never drained");
    end else if (n_match == 0 || n_halt == 0 || n_trig_wr == 0 || n_gated_wr == 0) begin
      report_fail($sformatf("Random traffic missed a case (match %0d halt %0d wr %0d gated %0d)",
                            n_match, n_halt, n_trig_wr, n_gated_wr));
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

/* dbg_trig.f */
source/dbg_trig_pkg.sv
source/dbg_csr_decode.sv
source/dbg_trigger_bank.sv
source/dbg_halt_ctrl.sv
source/dbg_trig_top.sv
dv/dbg_trig_props.sv
dv/dbg_trig_tb.sv
